// ==== sources.f ====
verilog/memTypesPkg.sv
verilog/ctrlPkg.sv
verilog/dualPortRam.sv
verilog/storeController.sv
verilog/readArbiter.sv
verilog/memController.sv
verilog/memSubsystem.sv
testbench/memSubsystem_checker.sv
testbench/memSubsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module memSubsystem_tb -o memSubsystemSim
./obj_dir/memSubsystemSim > sim.log 2>&1

if grep -qx "No errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// ==== testbench/memSubsystem_tb.sv ====
`timescale 1ns/1ps
module memSubsystem_tb;

  localparam int numControls = 2;
  localparam int numLoads    = 3;
  localparam int numStores   = 2;
  localparam int addrW       = memTypesPkg::addrWidth;
  localparam int dataW       = memTypesPkg::dataWidth;
  localparam int countW      = ctrlPkg::countWidth;
  localparam int waitLimit   = 200;

  typedef enum int {chStart, chCtrl, chEnd, chStore, chLoad} chanT;

  logic clk, rstN;
  logic memStartValid, memStartReady, memEndValid, memEndReady, ctrlEndValid, ctrlEndReady;
  logic [numControls*countW-1:0] ctrl;
  logic [numControls-1:0]        ctrlValid, ctrlReady;
  logic [numLoads*addrW-1:0]     ldAddr;
  logic [numLoads*dataW-1:0]     ldData;
  logic [numLoads-1:0]           ldAddrValid, ldAddrReady, ldDataValid;
  logic [numLoads-1:0]           ldDataReady = '1;
  logic [numStores*addrW-1:0]    stAddr;
  logic [numStores*dataW-1:0]    stData;
  logic [numStores-1:0]          stAddrValid, stAddrReady, stDataValid, stDataReady;

  // Reference memory and per-port expected load words
  memTypesPkg::dataT refMem [memTypesPkg::ramDepth];
  memTypesPkg::dataT expQ [numLoads][$];
  logic [numLoads-1:0] issued1, issued2;
  int          pendingModel;
  logic        endModel, sameCycleHit, randomReady;
  logic [31:0] seed;
  int          errorCount, checkCount;

  memSubsystem #(
    .numControls(numControls),
    .numLoads   (numLoads),
    .numStores  (numStores)
  ) u_memSubsystem (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] nextRand();
    seed = xorshift(seed);
    return seed;
  endfunction

  // Word a load should return, taken before any store in the same cycle
  function automatic memTypesPkg::dataT expectedLoad(input memTypesPkg::addrT a);
    return refMem[a];
  endfunction

  function automatic logic readyOf(input chanT ch, input int p);
    case (ch)
      chStart: return memStartReady;
      chCtrl:  return ctrlReady[p];
      chEnd:   return ctrlEndReady;
      chStore: return stAddrReady[p] && stDataReady[p];
      default: return ldAddrReady[p];
    endcase
  endfunction

  function automatic int pendingLoads();
    int n;
    n = 0;
    for (int i = 0; i < numLoads; i++) begin
      n += expQ[i].size();
    end
    return n;
  endfunction

  task automatic logFailure(input string msg);
    errorCount++;
    $display("%s", msg);
  endtask

  task automatic logMismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    errorCount++;
    $display("mismatch %s expected %h actual %h", name, exp, act);
  endtask

  task automatic finishRun();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  task automatic timeoutStop(input string what);
    logFailure({"timeout waiting for ", what});
    finishRun();
  endtask

  // Holds the caller until the channel transfers, returns 1 ns after that edge
  task automatic awaitTransfer(input chanT ch, input int p);
    int t;
    t = 0;
    @(negedge clk);
    while (!readyOf(ch, p)) begin
      t++;
      if (t > waitLimit) begin
        timeoutStop($sformatf("ready on %s port %0d", ch.name(), p));
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic startRun();
    memStartValid = 1'b1;
    awaitTransfer(chStart, 0);
    memStartValid = 1'b0;
  endtask

  task automatic sendEnd();
    ctrlEndValid = 1'b1;
    awaitTransfer(chEnd, 0);
    ctrlEndValid = 1'b0;
  endtask

  task automatic sendCtrl(input int p, input ctrlPkg::countT n);
    ctrl[p*countW +: countW] = n;
    ctrlValid[p] = 1'b1;
    awaitTransfer(chCtrl, p);
    ctrlValid[p] = 1'b0;
  endtask

  task automatic storeWord(input int p, input memTypesPkg::addrT a, input memTypesPkg::dataT d);
    stAddr[p*addrW +: addrW] = a;
    stData[p*dataW +: dataW] = d;
    stAddrValid[p] = 1'b1;
    stDataValid[p] = 1'b1;
    awaitTransfer(chStore, p);
    stAddrValid[p] = 1'b0;
    stDataValid[p] = 1'b0;
  endtask

  task automatic loadWord(input int p, input memTypesPkg::addrT a);
    ldAddr[p*addrW +: addrW] = a;
    ldAddrValid[p] = 1'b1;
    awaitTransfer(chLoad, p);
    ldAddrValid[p] = 1'b0;
  endtask

  // Random addresses in the filled block, with short gaps
  task automatic loadBurst(input int p);
    for (int n = 0; n < 12; n++) begin
      loadWord(p, memTypesPkg::addrT'(32'h100 + (nextRand() & 32'hf)));
      repeat (int'(nextRand() & 32'h1)) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic waitLoadsDone();
    int t;
    t = 0;
    while (pendingLoads() != 0) begin
      t++;
      if (t > waitLimit) begin
        timeoutStop("load data to drain");
      end
      @(posedge clk);
      #1;
    end
  endtask

  // Holds memEndReady low for some cycles before taking the token
  task automatic takeMemEnd(input int hold);
    int t;
    t = 0;
    @(negedge clk);
    while (!memEndValid) begin
      t++;
      if (t > waitLimit) begin
        timeoutStop("memEndValid");
      end
      @(negedge clk);
    end
    repeat (hold) begin
      @(negedge clk);
      checkCount++;
      if (!memEndValid) begin
        logFailure("memEndValid dropped while memEndReady was low");
      end
    end
    @(posedge clk);
    #1;
    memEndReady = 1'b1;
    @(posedge clk);
    #1;
    memEndReady = 1'b0;
    @(negedge clk);
    if (memEndValid) begin
      logFailure("memEndValid still high after the end token was taken");
    end
    @(posedge clk);
    #1;
  endtask

  // Load data back-pressure
  always @(posedge clk) begin
    logic [31:0] r;
    #1;
    if (randomReady) begin
      r = nextRand();
      ldDataReady = r[numLoads-1:0];
    end else begin
      ldDataReady = '1;
    end
  end

  // Compare process and reference model updates, sampled mid-cycle
  always @(negedge clk) begin
    logic [numLoads-1:0] loadXfer;
    memTypesPkg::dataT   exp;
    memTypesPkg::dataT   act;
    if (rstN) begin
      checkCount++;
      if (memEndValid && (pendingModel != 0 || !endModel)) begin
        logFailure("memEndValid raised before all announced stores and ctrlEnd");
      end
      if (stAddrValid[0] && stDataValid[0] && stAddrReady[1]) begin
        logFailure("store port 1 was served before waiting port 0");
      end
      for (int i = 0; i < numLoads; i++) begin
        if (issued1[i] && ldDataValid[i]) begin
          logFailure($sformatf("ldDataValid on port %0d came a cycle early", i));
        end
        if (issued2[i] && !ldDataValid[i]) begin
          logFailure($sformatf("ldDataValid on port %0d did not rise in time", i));
        end
        if (ldDataValid[i] && ldDataReady[i]) begin
          checkCount++;
          act = ldData[i*dataW +: dataW];
          if (expQ[i].size() == 0) begin
            logFailure($sformatf("load data on port %0d with no load issued", i));
          end else begin
            exp = expQ[i].pop_front();
            if (exp !== act) begin
              logMismatch($sformatf("load port %0d", i), exp, act);
            end
          end
        end
      end
      loadXfer = ldAddrValid & ldAddrReady;
      issued2  = issued1;
      issued1  = loadXfer;
      for (int i = 0; i < numLoads; i++) begin
        if (loadXfer[i]) begin
          expQ[i].push_back(expectedLoad(ldAddr[i*addrW +: addrW]));
        end
      end
      for (int j = 0; j < numStores; j++) begin
        if (stAddrValid[j] && stAddrReady[j] && stDataValid[j]) begin
          for (int i = 0; i < numLoads; i++) begin
            if (loadXfer[i] && ldAddr[i*addrW +: addrW] == stAddr[j*addrW +: addrW]) begin
              sameCycleHit = 1'b1;
            end
          end
          refMem[stAddr[j*addrW +: addrW]] = stData[j*dataW +: dataW];
          pendingModel--;
        end
      end
      for (int k = 0; k < numControls; k++) begin
        if (ctrlValid[k] && ctrlReady[k]) begin
          pendingModel += int'(ctrlPkg::countT'(ctrl[k*countW +: countW]));
        end
      end
      if (ctrlEndValid && ctrlEndReady) begin
        endModel = 1'b1;
      end
      if (memEndValid && memEndReady) begin
        endModel = 1'b0;
      end
    end
  end

  initial begin
    clk           = 1'b0;
    rstN          = 1'b0;
    memStartValid = 1'b0;
    memEndReady   = 1'b0;
    ctrlEndValid  = 1'b0;
    ctrl          = '0;
    ctrlValid     = '0;
    ldAddr        = '0;
    ldAddrValid   = '0;
    stAddr        = '0;
    stData        = '0;
    stAddrValid   = '0;
    stDataValid   = '0;
    issued1       = '0;
    issued2       = '0;
    pendingModel  = 0;
    endModel      = 1'b0;
    sameCycleHit  = 1'b0;
    randomReady   = 1'b0;
    seed          = 32'hf542;
    errorCount    = 0;
    checkCount    = 0;
    repeat (5) @(posedge clk);
    #1;
    rstN = 1'b1;

    // Token of 16 stores, ctrlEnd first, then the stores and a readback on every port
    startRun();
    sendCtrl(0, ctrlPkg::countT'(16));
    sendEnd();
    for (int i = 0; i < 16; i++) begin
      storeWord(i % numStores, memTypesPkg::addrT'(32'h100 + i), nextRand());
    end
    takeMemEnd(3);
    for (int p = 0; p < numLoads; p++) begin
      for (int i = 0; i < 16; i++) begin
        loadWord(p, memTypesPkg::addrT'(32'h100 + i));
      end
    end
    waitLoadsDone();

    // All load ports at once under random back-pressure
    randomReady = 1'b1;
    fork
      loadBurst(0);
      loadBurst(1);
      loadBurst(2);
    join
    waitLoadsDone();
    randomReady = 1'b0;

    // Both store ports valid together, first pair hits one address
    startRun();
    sendCtrl(1, ctrlPkg::countT'(4));
    fork
      storeWord(0, 10'h200, 32'h0000_aaaa);
      storeWord(1, 10'h200, 32'h0000_bbbb);
    join
    fork
      storeWord(0, 10'h201, 32'h1111_0000);
      storeWord(1, 10'h202, 32'h2222_0000);
    join
    sendEnd();
    takeMemEnd(0);
    for (int i = 0; i < 3; i++) begin
      loadWord(2, memTypesPkg::addrT'(32'h200 + i));
    end
    waitLoadsDone();

    // Stores ahead of their token drive the count negative
    startRun();
    for (int i = 0; i < 3; i++) begin
      storeWord(1, memTypesPkg::addrT'(32'h300 + i), nextRand());
    end
    sendCtrl(0, ctrlPkg::countT'(3));
    sendEnd();
    takeMemEnd(2);
    for (int i = 0; i < 3; i++) begin
      loadWord(0, memTypesPkg::addrT'(32'h300 + i));
    end
    waitLoadsDone();

    // Load and store to one address in one cycle
    startRun();
    sendCtrl(0, ctrlPkg::countT'(1));
    fork
      storeWord(0, 10'h105, 32'hdead_0105);
      loadWord(1, 10'h105);
    join
    checkCount++;
    if (!sameCycleHit) begin
      logFailure("load and store to one address did not transfer in one cycle");
    end
    sendEnd();
    takeMemEnd(0);
    loadWord(1, 10'h105);
    waitLoadsDone();
    finishRun();
  end

endmodule

// ==== testbench/memSubsystem_checker.sv ====
`timescale 1ns/1ps
module memSubsystem_checker #(
  parameter int numLoads  = 3,
  parameter int numStores = 2
) (
  input logic                 clk,
  input logic                 rstN,
  input logic                 memEndValid,
  input logic                 memEndReady,
  input logic [numLoads-1:0]  ldDataValid,
  input logic [numLoads-1:0]  ldDataReady,
  input logic                 loadEn,
  input logic [numStores-1:0] stAddrValid,
  input logic [numStores-1:0] stAddrReady,
  input logic [numStores-1:0] stDataValid,
  input logic [numStores-1:0] stDataReady,
  input logic                 storeEn
);

  // End token stays up until taken
  assert property (@(posedge clk) disable iff (!rstN)
    memEndValid && !memEndReady |=> memEndValid)
    else $error("memEndValid dropped before memEndReady");

  for (genvar g = 0; g < numLoads; g++) begin : genLdHold
    assert property (@(posedge clk) disable iff (!rstN)
      ldDataValid[g] && !ldDataReady[g] |=> ldDataValid[g])
      else $error("ldDataValid dropped before ldDataReady on port %0d", g);
  end

  // One RAM write port, so one store per cycle
  assert property (@(posedge clk) disable iff (!rstN)
    $onehot0(stAddrValid & stAddrReady & stDataValid & stDataReady))
    else $error("more than one store transfer in a cycle");

  assert property (@(posedge clk) disable iff (!rstN)
    storeEn |-> $onehot(stAddrValid & stAddrReady & stDataValid & stDataReady))
    else $error("storeEn without a store port handshake");

  // First cycle out of reset
  assert property (@(posedge clk)
    $rose(rstN) |-> !loadEn && !memEndValid && (ldDataValid == '0))
    else $error("valid or loadEn high right after reset");

endmodule

bind memController memSubsystem_checker #(
  .numLoads (numLoads),
  .numStores(numStores)
) u_checker (
  .clk        (clk),
  .rstN       (rstN),
  .memEndValid(memEndValid),
  .memEndReady(memEndReady),
  .ldDataValid(ldDataValid),
  .ldDataReady(ldDataReady),
  .loadEn     (loadEn),
  .stAddrValid(stAddrValid),
  .stAddrReady(stAddrReady),
  .stDataValid(stDataValid),
  .stDataReady(stDataReady),
  .storeEn    (storeEn)
);

// ==== verilog/memSubsystem.sv ====
`timescale 1ns/1ps
module memSubsystem #(
  parameter int numControls = 2,
  parameter int numLoads    = 3,
  parameter int numStores   = 2
) (
  input  logic                                        clk,
  input  logic                                        rstN,
  input  logic                                        memStartValid,
  output logic                                        memStartReady,
  output logic                                        memEndValid,
  input  logic                                        memEndReady,
  input  logic                                        ctrlEndValid,
  output logic                                        ctrlEndReady,
  input  logic [numControls*ctrlPkg::countWidth-1:0]  ctrl,
  input  logic [numControls-1:0]                      ctrlValid,
  output logic [numControls-1:0]                      ctrlReady,
  input  logic [numLoads*memTypesPkg::addrWidth-1:0]  ldAddr,
  input  logic [numLoads-1:0]                         ldAddrValid,
  output logic [numLoads-1:0]                         ldAddrReady,
  output logic [numLoads*memTypesPkg::dataWidth-1:0]  ldData,
  output logic [numLoads-1:0]                         ldDataValid,
  input  logic [numLoads-1:0]                         ldDataReady,
  input  logic [numStores*memTypesPkg::addrWidth-1:0] stAddr,
  input  logic [numStores-1:0]                        stAddrValid,
  output logic [numStores-1:0]                        stAddrReady,
  input  logic [numStores*memTypesPkg::dataWidth-1:0] stData,
  input  logic [numStores-1:0]                        stDataValid,
  output logic [numStores-1:0]                        stDataReady
);

  // Controller to RAM
  logic              loadEn;
  memTypesPkg::addrT loadAddr;
  memTypesPkg::dataT loadData;
  logic              storeEn;
  memTypesPkg::addrT storeAddr;
  memTypesPkg::dataT storeData;

  memController #(
    .numControls(numControls),
    .numLoads   (numLoads),
    .numStores  (numStores)
  ) u_memController (
    .clk          (clk),
    .rstN         (rstN),
    .memStartValid(memStartValid),
    .memStartReady(memStartReady),
    .memEndValid  (memEndValid),
    .memEndReady  (memEndReady),
    .ctrlEndValid (ctrlEndValid),
    .ctrlEndReady (ctrlEndReady),
    .ctrl         (ctrl),
    .ctrlValid    (ctrlValid),
    .ctrlReady    (ctrlReady),
    .ldAddr       (ldAddr),
    .ldAddrValid  (ldAddrValid),
    .ldAddrReady  (ldAddrReady),
    .ldData       (ldData),
    .ldDataValid  (ldDataValid),
    .ldDataReady  (ldDataReady),
    .stAddr       (stAddr),
    .stAddrValid  (stAddrValid),
    .stAddrReady  (stAddrReady),
    .stData       (stData),
    .stDataValid  (stDataValid),
    .stDataReady  (stDataReady),
    .loadData     (loadData),
    .loadEn       (loadEn),
    .loadAddr     (loadAddr),
    .storeEn      (storeEn),
    .storeAddr    (storeAddr),
    .storeData    (storeData)
  );

  dualPortRam u_dualPortRam (
    .clk      (clk),
    .loadEn   (loadEn),
    .loadAddr (loadAddr),
    .loadData (loadData),
    .storeEn  (storeEn),
    .storeAddr(storeAddr),
    .storeData(storeData)
  );

endmodule

// ==== verilog/memController.sv ====
`timescale 1ns/1ps
module memController #(
  parameter int numControls = 2,
  parameter int numLoads    = 3,
  parameter int numStores   = 2
) (
  input  logic                                        clk,
  input  logic                                        rstN,
  input  logic                                        memStartValid,
  output logic                                        memStartReady,
  output logic                                        memEndValid,
  input  logic                                        memEndReady,
  input  logic                                        ctrlEndValid,
  output logic                                        ctrlEndReady,
  input  logic [numControls*ctrlPkg::countWidth-1:0]  ctrl,
  input  logic [numControls-1:0]                      ctrlValid,
  output logic [numControls-1:0]                      ctrlReady,
  // Loads
  input  logic [numLoads*memTypesPkg::addrWidth-1:0]  ldAddr,
  input  logic [numLoads-1:0]                         ldAddrValid,
  output logic [numLoads-1:0]                         ldAddrReady,
  output logic [numLoads*memTypesPkg::dataWidth-1:0]  ldData,
  output logic [numLoads-1:0]                         ldDataValid,
  input  logic [numLoads-1:0]                         ldDataReady,
  // Stores
  input  logic [numStores*memTypesPkg::addrWidth-1:0] stAddr,
  input  logic [numStores-1:0]                        stAddrValid,
  output logic [numStores-1:0]                        stAddrReady,
  input  logic [numStores*memTypesPkg::dataWidth-1:0] stData,
  input  logic [numStores-1:0]                        stDataValid,
  output logic [numStores-1:0]                        stDataReady,
  // Dual-port RAM
  input  memTypesPkg::dataT                           loadData,
  output logic                                        loadEn,
  output memTypesPkg::addrT                           loadAddr,
  output logic                                        storeEn,
  output memTypesPkg::addrT                           storeAddr,
  output memTypesPkg::dataT                           storeData
);

  // Write side with run control
  storeController #(
    .numControls(numControls),
    .numStores  (numStores)
  ) u_storeController (
    .clk          (clk),
    .rstN         (rstN),
    .memStartValid(memStartValid),
    .memStartReady(memStartReady),
    .memEndValid  (memEndValid),
    .memEndReady  (memEndReady),
    .ctrlEndValid (ctrlEndValid),
    .ctrlEndReady (ctrlEndReady),
    .ctrl         (ctrl),
    .ctrlValid    (ctrlValid),
    .ctrlReady    (ctrlReady),
    .stAddr       (stAddr),
    .stAddrValid  (stAddrValid),
    .stAddrReady  (stAddrReady),
    .stData       (stData),
    .stDataValid  (stDataValid),
    .stDataReady  (stDataReady),
    .storeEn      (storeEn),
    .storeAddr    (storeAddr),
    .storeData    (storeData)
  );

  // Read side
  readArbiter #(
    .numLoads(numLoads)
  ) u_readArbiter (
    .clk        (clk),
    .rstN       (rstN),
    .ldAddr     (ldAddr),
    .ldAddrValid(ldAddrValid),
    .ldAddrReady(ldAddrReady),
    .ldData     (ldData),
    .ldDataValid(ldDataValid),
    .ldDataReady(ldDataReady),
    .loadEn     (loadEn),
    .loadAddr   (loadAddr),
    .loadData   (loadData)
  );

endmodule

// ==== verilog/readArbiter.sv ====
`timescale 1ns/1ps
module readArbiter #(
  parameter int numLoads = 3
) (
  input  logic                                       clk,
  input  logic                                       rstN,
  // Load address channels
  input  logic [numLoads*memTypesPkg::addrWidth-1:0] ldAddr,
  input  logic [numLoads-1:0]                        ldAddrValid,
  output logic [numLoads-1:0]                        ldAddrReady,
  // Load data channels
  output logic [numLoads*memTypesPkg::dataWidth-1:0] ldData,
  output logic [numLoads-1:0]                        ldDataValid,
  input  logic [numLoads-1:0]                        ldDataReady,
  // RAM read port
  output logic                                       loadEn,
  output memTypesPkg::addrT                          loadAddr,
  input  memTypesPkg::dataT                          loadData
);

  localparam int addrW = memTypesPkg::addrWidth;
  localparam int dataW = memTypesPkg::dataWidth;
  localparam int ptrW  = (numLoads > 1) ? $clog2(numLoads) : 1;

  logic [ptrW-1:0]     rrPtr;
  logic [ptrW-1:0]     nextPtr;
  logic [numLoads-1:0] eligible;
  logic [numLoads-1:0] inFlight;
  logic [numLoads-1:0] regValid;
  memTypesPkg::dataT   regData [numLoads];

  // Register must be free by the time the RAM word comes back
  assign eligible = ldAddrValid & ~inFlight & (~regValid | ldDataReady);

  // Round-robin pick starting at rrPtr
  always_comb begin
    int   idx;
    logic found;
    ldAddrReady = '0;
    loadAddr    = ldAddr[addrW-1:0];
    nextPtr     = rrPtr;
    found       = 1'b0;
    for (int k = 0; k < numLoads; k++) begin
      idx = (int'(rrPtr) + k) % numLoads;
      if (!found && eligible[idx]) begin
        found            = 1'b1;
        ldAddrReady[idx] = 1'b1;
        loadAddr         = ldAddr[idx*addrW +: addrW];
        nextPtr          = ptrW'((idx + 1) % numLoads);
      end
    end
  end

  assign loadEn = |ldAddrReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      rrPtr    <= '0;
      inFlight <= '0;
      regValid <= '0;
    end else begin
      // One-hot owner of the word the RAM returns next cycle
      inFlight <= ldAddrReady;
      if (loadEn) begin
        rrPtr <= nextPtr;
      end
      for (int i = 0; i < numLoads; i++) begin
        if (inFlight[i]) begin
          regValid[i] <= 1'b1;
        end else if (ldDataReady[i]) begin
          regValid[i] <= 1'b0;
        end
      end
    end
  end

  // Capture the returning word for its port
  always_ff @(posedge clk) begin
    for (int i = 0; i < numLoads; i++) begin
      if (inFlight[i]) begin
        regData[i] <= loadData;
      end
    end
  end

  for (genvar g = 0; g < numLoads; g++) begin : genLdData
    assign ldData[g*dataW +: dataW] = regData[g];
  end

  assign ldDataValid = regValid;

endmodule

// ==== verilog/storeController.sv ====
`timescale 1ns/1ps
module storeController #(
  parameter int numControls = 2,
  parameter int numStores   = 2
) (
  input  logic                                        clk,
  input  logic                                        rstN,
  // Run start and end
  input  logic                                        memStartValid,
  output logic                                        memStartReady,
  output logic                                        memEndValid,
  input  logic                                        memEndReady,
  input  logic                                        ctrlEndValid,
  output logic                                        ctrlEndReady,
  // Control tokens, each one a number of stores still to come
  input  logic [numControls*ctrlPkg::countWidth-1:0]  ctrl,
  input  logic [numControls-1:0]                      ctrlValid,
  output logic [numControls-1:0]                      ctrlReady,
  // Store request channels
  input  logic [numStores*memTypesPkg::addrWidth-1:0] stAddr,
  input  logic [numStores-1:0]                        stAddrValid,
  output logic [numStores-1:0]                        stAddrReady,
  input  logic [numStores*memTypesPkg::dataWidth-1:0] stData,
  input  logic [numStores-1:0]                        stDataValid,
  output logic [numStores-1:0]                        stDataReady,
  // RAM write port
  output logic                                        storeEn,
  output memTypesPkg::addrT                           storeAddr,
  output memTypesPkg::dataT                           storeData
);

  localparam int addrW  = memTypesPkg::addrWidth;
  localparam int dataW  = memTypesPkg::dataWidth;
  localparam int countW = ctrlPkg::countWidth;

  ctrlPkg::ctrlStateT state;
  ctrlPkg::countT     pendingCount;
  ctrlPkg::countT     ctrlAdd;
  ctrlPkg::countT     storeDec;
  logic               endSeen;
  logic               storeOk;
  logic               runDone;

  assign memStartReady = (state == ctrlPkg::ctrlIdle) && memStartValid;
  assign ctrlEndReady  = (state == ctrlPkg::ctrlRun) && !endSeen;
  assign memEndValid   = (state == ctrlPkg::ctrlDone);

  // Control tokens during a run, lowest port wins
  always_comb begin
    ctrlReady = '0;
    ctrlAdd   = '0;
    for (int i = numControls - 1; i >= 0; i--) begin
      if (ctrlValid[i] && state == ctrlPkg::ctrlRun) begin
        ctrlReady    = '0;
        ctrlReady[i] = 1'b1;
        ctrlAdd      = ctrl[i*countW +: countW];
      end
    end
  end

  // Stores are held off only while the end token is being handed out
  assign storeOk = (state != ctrlPkg::ctrlDone);

  // Fixed priority store select, needs address and data together
  always_comb begin
    stAddrReady = '0;
    storeAddr   = stAddr[addrW-1:0];
    storeData   = stData[dataW-1:0];
    for (int i = numStores - 1; i >= 0; i--) begin
      if (storeOk && stAddrValid[i] && stDataValid[i]) begin
        stAddrReady    = '0;
        stAddrReady[i] = 1'b1;
        storeAddr      = stAddr[i*addrW +: addrW];
        storeData      = stData[i*dataW +: dataW];
      end
    end
  end

  assign stDataReady = stAddrReady;
  assign storeEn     = |stAddrReady;
  assign storeDec    = storeEn ? ctrlPkg::countT'(1) : '0;

  // All announced stores done and nothing more to come
  assign runDone = endSeen && (pendingCount == '0) && (ctrlValid == '0) && !storeEn;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state        <= ctrlPkg::ctrlIdle;
      pendingCount <= '0;
      endSeen      <= 1'b0;
    end else begin
      // Token and store may both land in one cycle
      pendingCount <= pendingCount + ctrlAdd - storeDec;
      case (state)
        ctrlPkg::ctrlIdle: begin
          if (memStartValid && memStartReady) begin
            state <= ctrlPkg::ctrlRun;
          end
        end
        ctrlPkg::ctrlRun: begin
          if (ctrlEndValid && ctrlEndReady) begin
            endSeen <= 1'b1;
          end
          if (runDone) begin
            state   <= ctrlPkg::ctrlDone;
            endSeen <= 1'b0;
          end
        end
        ctrlPkg::ctrlDone: begin
          // Wait here until the end token is taken
          if (memEndReady) begin
            state <= ctrlPkg::ctrlIdle;
          end
        end
        default: begin
          state <= ctrlPkg::ctrlIdle;
        end
      endcase
    end
  end

endmodule

// ==== verilog/dualPortRam.sv ====
`timescale 1ns/1ps
module dualPortRam (
  input  logic              clk,
  // Read port
  input  logic              loadEn,
  input  memTypesPkg::addrT loadAddr,
  output memTypesPkg::dataT loadData,
  // Write port
  input  logic              storeEn,
  input  memTypesPkg::addrT storeAddr,
  input  memTypesPkg::dataT storeData
);

  memTypesPkg::dataT mem [memTypesPkg::ramDepth];

  always_ff @(posedge clk) begin
    if (storeEn) begin
      mem[storeAddr] <= storeData;
    end
  end

  // Same-address collision returns the old word
  always_ff @(posedge clk) begin
    if (loadEn) begin
      loadData <= mem[loadAddr];
    end
  end

endmodule

// ==== verilog/ctrlPkg.sv ====
package ctrlPkg;

  // Width of one control token and of the pending store count
  localparam int countWidth = 16;

  // Goes negative when stores run ahead of their control token
  typedef logic signed [countWidth-1:0] countT;

  // Store controller run states
  typedef enum logic [1:0] {
    ctrlIdle,
    ctrlRun,
    ctrlDone
  } ctrlStateT;

endpackage

// ==== verilog/memTypesPkg.sv ====
package memTypesPkg;

  // Word and address widths of the on-chip RAM
  localparam int dataWidth = 32;
  localparam int addrWidth = 10;

  // Every address of addrT maps to one word
  localparam int ramDepth = 1 << addrWidth;

  // One memory word
  typedef logic [dataWidth-1:0] dataT;

  // Word address
  typedef logic [addrWidth-1:0] addrT;

endpackage
